// ==== hw/eth_mcf_pkg.sv ====
// MAC control frame types
package eth_mcf_pkg;

    // Reserved multicast address of 802.3 MAC control frames
    localparam logic [47:0] MCF_ETH_DST  = 48'h01_80_C2_00_00_01;

    localparam logic [15:0] MCF_ETH_TYPE = 16'h8808;  // MAC control EtherType

    // One parsed control frame as it leaves the receive parser
    typedef struct packed {
        logic [47:0] eth_dst;
        logic [15:0] eth_type;
        logic [15:0] opcode;
        logic [15:0] quanta;  // Pause time in units of 512 bit times
        logic [1:0]  ch;      // Index of the receiving MAC channel
    } mcf_t;

    // The part of a frame that a single channel still has to look at
    typedef struct packed {
        logic [15:0] opcode;
        logic [15:0] quanta;
    } mcf_ch_t;

endpackage

// ==== hw/lfc_csr_pkg.sv ====
// Flow control register map
package lfc_csr_pkg;

    localparam int REG_ADDR_W = 8;
    localparam int REG_DATA_W = 32;

    // Register blocks, channel n sits at base plus 4*n
    localparam logic [REG_ADDR_W-1:0] REG_CFG_BASE  = 8'h00;
    localparam logic [REG_ADDR_W-1:0] REG_XOFF_BASE = 8'h10;
    localparam logic [REG_ADDR_W-1:0] REG_XON_BASE  = 8'h20;

    localparam logic [15:0] CFG_OPCODE_RST = 16'h0001;  // 802.3 PAUSE opcode

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // Per-channel receive configuration
    typedef struct packed {
        logic        rx_lfc_en;
        logic [15:0] lfc_opcode;
    } ch_cfg_t;

    // Single-cycle pulses from a channel, one per accepted PAUSE frame
    typedef struct packed {
        logic xoff;
        logic xon;
    } ch_evt_t;

    // Every channel comes out of reset enabled with the standard opcode
    localparam ch_cfg_t CFG_RST = '{
        rx_lfc_en:  1'b1,
        lfc_opcode: CFG_OPCODE_RST
    };

endpackage

// ==== hw/lfc_quad.sv ====
// Quad receive flow control
module lfc_quad #(
    parameter int CNT           = 4,
    parameter int QUANTA_CYCLES = 8,  // 512 bit times at 64 bits per cycle
    parameter int CNT_W         = 16
) (
    input  wire logic                                  rx_clk,
    input  wire logic                                  rst,

    // Parsed MAC control frames
    input  wire eth_mcf_pkg::mcf_t                     mcf_in,
    input  wire logic                                  mcf_valid,

    // AXI4-Lite slave
    input  wire logic [lfc_csr_pkg::REG_ADDR_W-1:0]    awaddr,
    input  wire logic                                  awvalid,
    output wire logic                                  awready,
    input  wire logic [lfc_csr_pkg::REG_DATA_W-1:0]    wdata,
    input  wire logic [lfc_csr_pkg::REG_DATA_W/8-1:0]  wstrb,
    input  wire logic                                  wvalid,
    output wire logic                                  wready,
    output wire logic [1:0]                            bresp,
    output wire logic                                  bvalid,
    input  wire logic                                  bready,
    input  wire logic [lfc_csr_pkg::REG_ADDR_W-1:0]    araddr,
    input  wire logic                                  arvalid,
    output wire logic                                  arready,
    output wire logic [lfc_csr_pkg::REG_DATA_W-1:0]    rdata,
    output wire logic [1:0]                            rresp,
    output wire logic                                  rvalid,
    input  wire logic                                  rready,

    output wire logic [CNT-1:0]                        rx_pause
);

    import eth_mcf_pkg::*;
    import lfc_csr_pkg::*;

    wire mcf_ch_t [CNT-1:0] ch_frame;
    wire logic [CNT-1:0]    ch_frame_valid;
    wire ch_cfg_t [CNT-1:0] ch_cfg;
    wire ch_evt_t [CNT-1:0] ch_evt;

    mcf_rx_dispatch #(
        .CNT(CNT)
    ) dispatch_inst (
        .rx_clk(rx_clk),
        .rst(rst),
        .mcf_in(mcf_in),
        .mcf_valid(mcf_valid),
        .ch_frame(ch_frame),
        .ch_frame_valid(ch_frame_valid)
    );

    // One receiver per lane
    for (genvar n = 0; n < CNT; n++) begin : ch
        lfc_rx_ch #(
            .QUANTA_CYCLES(QUANTA_CYCLES)
        ) ch_inst (
            .rx_clk(rx_clk),
            .rst(rst),
            .frame(ch_frame[n]),
            .frame_valid(ch_frame_valid[n]),
            .cfg(ch_cfg[n]),
            .evt(ch_evt[n]),
            .pause(rx_pause[n])
        );
    end

    lfc_stat_csr #(
        .CNT(CNT),
        .CNT_W(CNT_W)
    ) csr_inst (
        .rx_clk(rx_clk),
        .rst(rst),
        .awaddr(awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata(wdata),
        .wstrb(wstrb),
        .wvalid(wvalid),
        .wready(wready),
        .bresp(bresp),
        .bvalid(bvalid),
        .bready(bready),
        .araddr(araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata(rdata),
        .rresp(rresp),
        .rvalid(rvalid),
        .rready(rready),
        .ch_cfg(ch_cfg),
        .ch_evt(ch_evt)
    );

endmodule

// ==== hw/lfc_rx_ch.sv ====
// Per-channel PAUSE receiver
module lfc_rx_ch #(
    parameter int QUANTA_CYCLES = 8
) (
    input  wire logic                    rx_clk,
    input  wire logic                    rst,

    // Frame routed to this channel by the dispatcher
    input  wire eth_mcf_pkg::mcf_ch_t    frame,
    input  wire logic                    frame_valid,

    // Configuration and event reporting
    input  wire lfc_csr_pkg::ch_cfg_t    cfg,
    output lfc_csr_pkg::ch_evt_t         evt,

    output logic                         pause
);

    // Wide enough for the largest quanta times the cycles per quantum
    localparam int TMR_W = 16 + $clog2(QUANTA_CYCLES);

    logic             frame_hit;
    logic             is_xoff;
    logic             is_xon;
    logic [TMR_W-1:0] tmr_load;
    logic [TMR_W-1:0] tmr;
    logic [TMR_W-1:0] tmr_next;

    // A frame counts only when the channel is enabled and the opcode matches
    assign frame_hit = frame_valid && cfg.rx_lfc_en && (frame.opcode == cfg.lfc_opcode);

    assign is_xoff = frame_hit && (frame.quanta != '0);
    assign is_xon  = frame_hit && (frame.quanta == '0);  // Zero quanta means resume

    assign tmr_load = TMR_W'(frame.quanta) * TMR_W'(QUANTA_CYCLES);

    always_comb begin
        evt.xoff = is_xoff;
        evt.xon  = is_xon;
    end

    // Priority is disable, then a new frame, then the running countdown
    always_comb begin
        tmr_next = tmr;
        if (!cfg.rx_lfc_en) begin
            tmr_next = '0;  // Disabling flow control releases the link at once
        end else if (is_xoff) begin
            tmr_next = tmr_load;  // A later XOFF restarts the count from the top
        end else if (is_xon) begin
            tmr_next = '0;
        end else if (tmr != '0) begin
            tmr_next = tmr - 1'b1;
        end
    end

    // Pause is registered alongside the timer so it tracks a nonzero count
    always_ff @(posedge rx_clk) begin
        if (rst) begin
            tmr   <= '0;
            pause <= 1'b0;
        end else begin
            tmr   <= tmr_next;
            pause <= tmr_next != '0;
        end
    end

endmodule

// ==== hw/lfc_stat_csr.sv ====
// Flow control registers and counters
module lfc_stat_csr #(
    parameter int CNT   = 4,
    parameter int CNT_W = 16
) (
    input  wire logic                                  rx_clk,
    input  wire logic                                  rst,

    // AXI4-Lite slave
    input  wire logic [lfc_csr_pkg::REG_ADDR_W-1:0]    awaddr,
    input  wire logic                                  awvalid,
    output logic                                       awready,
    input  wire logic [lfc_csr_pkg::REG_DATA_W-1:0]    wdata,
    input  wire logic [lfc_csr_pkg::REG_DATA_W/8-1:0]  wstrb,
    input  wire logic                                  wvalid,
    output logic                                       wready,
    output logic [1:0]                                 bresp,
    output logic                                       bvalid,
    input  wire logic                                  bready,
    input  wire logic [lfc_csr_pkg::REG_ADDR_W-1:0]    araddr,
    input  wire logic                                  arvalid,
    output logic                                       arready,
    output logic [lfc_csr_pkg::REG_DATA_W-1:0]         rdata,
    output logic [1:0]                                 rresp,
    output logic                                       rvalid,
    input  wire logic                                  rready,

    // Channel side
    output lfc_csr_pkg::ch_cfg_t [CNT-1:0]             ch_cfg,
    input  wire lfc_csr_pkg::ch_evt_t [CNT-1:0]        ch_evt
);

    import lfc_csr_pkg::*;

    logic                      wr_en;
    logic                      rd_en;
    logic [REG_DATA_W-1:0]     rd_data;
    logic [CNT-1:0][CNT_W-1:0] xoff_cnt;
    logic [CNT-1:0][CNT_W-1:0] xon_cnt;

    // True when addr selects the word of channel n in the block at base
    function automatic logic reg_hit(
        input logic [REG_ADDR_W-1:0] addr,
        input logic [REG_ADDR_W-1:0] base,
        input int                    n
    );
        return {addr[REG_ADDR_W-1:2], 2'b00} == REG_ADDR_W'(base + 4 * n);
    endfunction

    // A held response blocks the next transaction of the same kind
    assign wr_en = awvalid && wvalid && !bvalid;
    assign rd_en = arvalid && !rvalid;

    assign awready = wr_en;
    assign wready  = wr_en;
    assign arready = rd_en;
    assign bresp   = RESP_OKAY;
    assign rresp   = RESP_OKAY;

    always_ff @(posedge rx_clk) begin
        if (rst) begin
            ch_cfg <= {CNT{CFG_RST}};
        end else if (wr_en) begin
            for (int n = 0; n < CNT; n++) begin
                if (reg_hit(awaddr, REG_CFG_BASE, n)) begin
                    if (wstrb[0])
                        ch_cfg[n].rx_lfc_en <= wdata[0];
                    if (wstrb[2])
                        ch_cfg[n].lfc_opcode[7:0] <= wdata[23:16];
                    if (wstrb[3])
                        ch_cfg[n].lfc_opcode[15:8] <= wdata[31:24];
                end
            end
        end
    end

    // Event counters stick at all ones instead of wrapping
    always_ff @(posedge rx_clk) begin
        if (rst) begin
            xoff_cnt <= '0;
            xon_cnt  <= '0;
        end else begin
            for (int n = 0; n < CNT; n++) begin
                if (ch_evt[n].xoff && xoff_cnt[n] != '1)
                    xoff_cnt[n] <= xoff_cnt[n] + 1'b1;
                if (ch_evt[n].xon && xon_cnt[n] != '1)
                    xon_cnt[n] <= xon_cnt[n] + 1'b1;
            end
        end
    end

    always_comb begin
        rd_data = '0;  // Anything outside the map reads back as zero
        for (int n = 0; n < CNT; n++) begin
            if (reg_hit(araddr, REG_CFG_BASE, n))
                rd_data = {ch_cfg[n].lfc_opcode, 15'd0, ch_cfg[n].rx_lfc_en};
            if (reg_hit(araddr, REG_XOFF_BASE, n))
                rd_data = REG_DATA_W'(xoff_cnt[n]);
            if (reg_hit(araddr, REG_XON_BASE, n))
                rd_data = REG_DATA_W'(xon_cnt[n]);
        end
    end

    always_ff @(posedge rx_clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_en)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;

            if (rd_en)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    // Read data is sampled with the address and held while rvalid waits
    always_ff @(posedge rx_clk) begin
        if (rd_en) begin
            rdata <= rd_data;
        end
    end

endmodule

// ==== hw/mcf_rx_dispatch.sv ====
// Control frame dispatcher
module mcf_rx_dispatch #(
    parameter int CNT = 4
) (
    input  wire logic                          rx_clk,
    input  wire logic                          rst,

    // Parsed control frames from the shared receive path
    input  wire eth_mcf_pkg::mcf_t             mcf_in,
    input  wire logic                          mcf_valid,

    // One slot per channel
    output eth_mcf_pkg::mcf_ch_t [CNT-1:0]     ch_frame,
    output logic [CNT-1:0]                     ch_frame_valid
);

    import eth_mcf_pkg::*;

    logic           dst_ok;
    logic           type_ok;
    logic           ch_ok;
    logic [CNT-1:0] ch_sel;

    // Checks shared by all channels
    assign dst_ok  = mcf_in.eth_dst == MCF_ETH_DST;
    assign type_ok = mcf_in.eth_type == MCF_ETH_TYPE;
    assign ch_ok   = int'(mcf_in.ch) < CNT;  // Index beyond the quad is dropped

    // One-hot channel select, all zero when the frame is rejected
    always_comb begin
        ch_sel = '0;
        if (mcf_valid && dst_ok && type_ok && ch_ok) begin
            ch_sel[mcf_in.ch] = 1'b1;
        end
    end

    // Only the selected slot takes the new fields
    always_ff @(posedge rx_clk) begin
        for (int i = 0; i < CNT; i++) begin
            if (ch_sel[i]) begin
                ch_frame[i].opcode <= mcf_in.opcode;
                ch_frame[i].quanta <= mcf_in.quanta;
            end
        end
    end

    always_ff @(posedge rx_clk) begin
        if (rst) begin
            ch_frame_valid <= '0;
        end else begin
            ch_frame_valid <= ch_sel;  // Valid lasts one cycle per frame
        end
    end

endmodule

// ==== lfc_quad.f ====
hw/eth_mcf_pkg.sv
hw/lfc_csr_pkg.sv
hw/mcf_rx_dispatch.sv
hw/lfc_rx_ch.sv
hw/lfc_stat_csr.sv
hw/lfc_quad.sv
tb/lfc_quad_props.sv
tb/lfc_quad_checker.sv
tb/lfc_quad_tb.sv

// ==== tb/lfc_quad_checker.sv ====
// Pause and counter reference model
module lfc_quad_checker #(
    parameter int CNT           = 4,
    parameter int QUANTA_CYCLES = 8,
    parameter int CNT_W         = 16
) (
    input  wire logic                rx_clk,
    input  wire logic                rst,
    input  wire eth_mcf_pkg::mcf_t   mcf_in,
    input  wire logic                mcf_valid,
    input  wire logic [7:0]          awaddr,
    input  wire logic                awvalid,
    input  wire logic [31:0]         wdata,
    input  wire logic [3:0]          wstrb,
    input  wire logic                wvalid,
    input  wire logic [1:0]          bresp,
    input  wire logic                bvalid,
    input  wire logic                bready,
    input  wire logic [7:0]          araddr,
    input  wire logic                arvalid,
    input  wire logic [31:0]         rdata,
    input  wire logic [1:0]          rresp,
    input  wire logic                rvalid,
    input  wire logic                rready,
    input  wire logic [CNT-1:0]      rx_pause,
    output int                       err_cnt,
    output int                       chk_cnt
);

    timeunit 1ns;
    timeprecision 1ps;

    import eth_mcf_pkg::*;

    localparam longint CNT_MAX = (longint'(1) << CNT_W) - 1;

    logic [CNT-1:0] s1_valid;  // Frame held in the dispatcher register
    logic [15:0]    s1_op [CNT];
    logic [15:0]    s1_q [CNT];
    longint         tmr [CNT];
    logic [CNT-1:0] pause_m;
    logic           en_m [CNT];
    logic [15:0]    op_m [CNT];
    longint         xoff_m [CNT];
    longint         xon_m [CNT];
    logic [31:0]    rd_exp [$];

    // Register contents as the map defines them, word index in addr[7:2]
    function automatic logic [31:0] reg_value(input logic [7:0] addr);
        int idx;
        idx = addr[7:2];
        if (idx < 4 && idx < CNT)
            return {op_m[idx], 15'd0, en_m[idx]};
        if (idx >= 4 && idx < 4 + CNT)
            return 32'(xoff_m[idx-4]);
        if (idx >= 8 && idx < 8 + CNT)
            return 32'(xon_m[idx-8]);
        return 32'd0;
    endfunction

    always @(posedge rx_clk) begin
        if (rst) begin
            s1_valid = '0;
            pause_m  = '0;
            rd_exp.delete();
            for (int n = 0; n < CNT; n++) begin
                tmr[n]    = 0;
                en_m[n]   = 1'b1;
                op_m[n]   = 16'h0001;
                xoff_m[n] = 0;
                xon_m[n]  = 0;
            end
        end else begin
            chk_cnt++;
            if (rx_pause !== pause_m) begin
                err_cnt++;
                $display("ERR %0t rx_pause expected %b actual %b", $time, pause_m, rx_pause);
            end
            if (bvalid && bready) begin
                chk_cnt++;
                if (bresp !== 2'b00) begin
                    err_cnt++;
                    $display("ERR %0t bresp expected %b actual %b", $time, 2'b00, bresp);
                end
            end
            if (rvalid && rready) begin
                chk_cnt++;
                if (rresp !== 2'b00) begin
                    err_cnt++;
                    $display("ERR %0t rresp expected %b actual %b", $time, 2'b00, rresp);
                end
                if (rd_exp.size() == 0) begin
                    err_cnt++;
                    $display("Read data returned at %0t with no read outstanding", $time);
                end else if (rdata !== rd_exp[0]) begin
                    err_cnt++;
                    $display("ERR %0t rdata expected %h actual %h", $time, rd_exp[0], rdata);
                    void'(rd_exp.pop_front());
                end else begin
                    void'(rd_exp.pop_front());
                end
            end
            if (arvalid && !rvalid)
                rd_exp.push_back(reg_value(araddr));  // Value as the address is taken
            for (int n = 0; n < CNT; n++) begin
                if (!en_m[n]) begin
                    tmr[n] = 0;
                end else if (s1_valid[n] && s1_op[n] == op_m[n]) begin
                    if (s1_q[n] != 0) begin
                        tmr[n] = longint'(s1_q[n]) * QUANTA_CYCLES;
                        if (xoff_m[n] < CNT_MAX) xoff_m[n]++;
                    end else begin
                        tmr[n] = 0;
                        if (xon_m[n] < CNT_MAX) xon_m[n]++;
                    end
                end else if (tmr[n] != 0) begin
                    tmr[n]--;
                end
                pause_m[n] = tmr[n] != 0;
            end
            for (int n = 0; n < CNT; n++) begin
                s1_valid[n] = mcf_valid && mcf_in.eth_dst == MCF_ETH_DST
                    && mcf_in.eth_type == MCF_ETH_TYPE && int'(mcf_in.ch) == n;
                if (s1_valid[n]) begin
                    s1_op[n] = mcf_in.opcode;
                    s1_q[n]  = mcf_in.quanta;
                end
            end
            // Config write lands after the channels have used the old value
            if (awvalid && wvalid && !bvalid && awaddr[7:4] == 4'h0 && awaddr[3:2] < CNT) begin
                if (wstrb[0]) en_m[awaddr[3:2]] = wdata[0];
                if (wstrb[2]) op_m[awaddr[3:2]][7:0] = wdata[23:16];
                if (wstrb[3]) op_m[awaddr[3:2]][15:8] = wdata[31:24];
            end
        end
    end

endmodule

// ==== tb/lfc_quad_props.sv ====
// Register block handshake properties
module lfc_quad_props (
    input wire logic                             rx_clk,
    input wire logic                             rst,
    input wire logic                             awready,
    input wire logic                             wready,
    input wire logic                             bvalid,
    input wire logic                             bready,
    input wire logic                             arready,
    input wire logic [31:0]                      rdata,
    input wire logic                             rvalid,
    input wire logic                             rready
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0;  // Failed assertions, summed into the testbench result

    // Responses hold until the master takes them
    a_bvalid_hold: assert property (@(posedge rx_clk) disable iff (rst)
        bvalid && !bready |=> bvalid) else begin
        $error("bvalid dropped without bready");
        fail_cnt++;
    end
    a_rvalid_hold: assert property (@(posedge rx_clk) disable iff (rst)
        rvalid && !rready |=> rvalid) else begin
        $error("rvalid dropped without rready");
        fail_cnt++;
    end

    // An accepted request is answered in the following cycle
    a_b_after_w: assert property (@(posedge rx_clk) disable iff (rst)
        awready && wready |=> bvalid) else begin
        $error("no write response after an accepted write");
        fail_cnt++;
    end
    a_r_after_ar: assert property (@(posedge rx_clk) disable iff (rst)
        arready |=> rvalid) else begin
        $error("no read response after an accepted read");
        fail_cnt++;
    end

    a_rdata_stable: assert property (@(posedge rx_clk) disable iff (rst)
        rvalid && !rready |=> $stable(rdata)) else begin
        $error("rdata changed while the read response waited");
        fail_cnt++;
    end

endmodule

// ==== tb/lfc_quad_tb.sv ====
// Quad flow control testbench
module lfc_quad_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import eth_mcf_pkg::*;

    localparam int CNT = 4;
    localparam int QUANTA_CYCLES = 8;
    localparam int CNT_W = 16;

    typedef struct {
        logic [47:0] dst;
        logic [15:0] etype;
        logic [15:0] opcode;
        logic [15:0] quanta;
        logic [1:0]  ch;
        logic        rnd_q;    // Take quanta from the LFSR instead
        int          gap;      // Idle cycles after the frame
        logic        cfg_wr;
        logic [7:0]  cfg_addr;
        logic [31:0] cfg_data;
    } row_t;

    logic rx_clk;
    logic rst;
    mcf_t mcf_in;
    logic mcf_valid;
    logic [7:0] awaddr;
    logic awvalid;
    logic awready;
    logic [31:0] wdata;
    logic [3:0] wstrb;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    logic [7:0] araddr;
    logic arvalid;
    logic arready;
    logic [31:0] rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready;
    logic [CNT-1:0] rx_pause;
    int err_cnt;
    int chk_cnt;
    int test_cnt;
    logic [31:0] lfsr;
    row_t rows [$];

    lfc_quad #(.CNT(CNT), .QUANTA_CYCLES(QUANTA_CYCLES), .CNT_W(CNT_W)) dut (
        .rx_clk(rx_clk), .rst(rst), .mcf_in(mcf_in), .mcf_valid(mcf_valid),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready), .wdata(wdata),
        .wstrb(wstrb), .wvalid(wvalid), .wready(wready), .bresp(bresp),
        .bvalid(bvalid), .bready(bready), .araddr(araddr), .arvalid(arvalid),
        .arready(arready), .rdata(rdata), .rresp(rresp), .rvalid(rvalid),
        .rready(rready), .rx_pause(rx_pause)
    );

    lfc_quad_checker #(.CNT(CNT), .QUANTA_CYCLES(QUANTA_CYCLES), .CNT_W(CNT_W)) model_chk (
        .rx_clk(rx_clk), .rst(rst), .mcf_in(mcf_in), .mcf_valid(mcf_valid),
        .awaddr(awaddr), .awvalid(awvalid), .wdata(wdata), .wstrb(wstrb),
        .wvalid(wvalid), .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .rdata(rdata), .rresp(rresp),
        .rvalid(rvalid), .rready(rready), .rx_pause(rx_pause),
        .err_cnt(err_cnt), .chk_cnt(chk_cnt)
    );

    bind lfc_stat_csr lfc_quad_props props (
        .rx_clk(rx_clk), .rst(rst), .awready(awready), .wready(wready),
        .bvalid(bvalid), .bready(bready), .arready(arready), .rdata(rdata),
        .rvalid(rvalid), .rready(rready)
    );

    always #50 rx_clk = ~rx_clk;

    // Right-shifting Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic add_row(input logic [47:0] dst, input logic [15:0] etype,
                           input logic [15:0] opcode, input logic [15:0] quanta,
                           input logic [1:0] ch, input logic rnd_q, input int gap,
                           input logic cfg_wr, input logic [7:0] cfg_addr,
                           input logic [31:0] cfg_data);
        row_t r;
        r = '{dst, etype, opcode, quanta, ch, rnd_q, gap, cfg_wr, cfg_addr, cfg_data};
        rows.push_back(r);
    endtask

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] stall;
        awaddr <= addr;
        wdata <= data;
        wstrb <= 4'hf;
        awvalid <= 1'b1;
        wvalid <= 1'b1;
        @(posedge rx_clk);
        while (!(awready && wready)) @(posedge rx_clk);
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        take_bits(2, stall);
        repeat (stall) @(posedge rx_clk);
        bready <= 1'b1;
        do @(posedge rx_clk); while (!bvalid);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr);
        logic [31:0] stall;
        araddr <= addr;
        arvalid <= 1'b1;
        @(posedge rx_clk);
        while (!arready) @(posedge rx_clk);
        arvalid <= 1'b0;
        take_bits(2, stall);
        repeat (stall) @(posedge rx_clk);
        rready <= 1'b1;
        do @(posedge rx_clk); while (!rvalid);
        rready <= 1'b0;
    endtask

    task automatic read_all_regs(input string what);
        int prev;
        prev = err_cnt;
        for (int a = 0; a < 12; a++) axi_read(8'(a * 4));
        repeat (2) @(posedge rx_clk);
        test_cnt++;
        $display("test %0d %0s: %0s", test_cnt, what, err_cnt == prev ? "ok" : "failed");
    endtask

    initial begin
        longint limit;
        logic [31:0] q;
        int prev;
        int total;
        rx_clk = 1'b0;
        rst = 1'b1;
        mcf_in = '0;
        mcf_valid = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        test_cnt = 0;
        lfsr = 32'hf15b_e9e2;
        add_row(MCF_ETH_DST, MCF_ETH_TYPE, 16'h1, 16'd3, 2'd0, 0, 40, 0, 8'h00, 0);
        add_row(MCF_ETH_DST, MCF_ETH_TYPE, 16'h1, 16'd10, 2'd1, 0, 20, 0, 8'h00, 0);
        add_row(MCF_ETH_DST, MCF_ETH_TYPE, 16'h1, 16'd4, 2'd1, 0, 45, 0, 8'h00, 0);
        add_row(MCF_ETH_DST, MCF_ETH_TYPE, 16'h1, 16'd20, 2'd2, 0, 10, 0, 8'h00, 0);
        add_row(MCF_ETH_DST, MCF_ETH_TYPE, 16'h1, 16'd0, 2'd2, 0, 10, 0, 8'h00, 0);
        add_row(48'h01_80_C2_00_00_02, MCF_ETH_TYPE, 16'h1, 16'd5, 2'd0, 0, 10, 0, 8'h00, 0);
        add_row(MCF_ETH_DST, 16'h0800, 16'h1, 16'd5, 2'd0, 0, 10, 0, 8'h00, 0);
        add_row(MCF_ETH_DST, MCF_ETH_TYPE, 16'h2, 16'd5, 2'd0, 0, 10, 0, 8'h00, 0);
        add_row(MCF_ETH_DST, MCF_ETH_TYPE, 16'h1, 16'd5, 2'd3, 0, 10, 1, 8'h0c, 32'h0001_0000);
        add_row(MCF_ETH_DST, MCF_ETH_TYPE, 16'h2, 16'd5, 2'd3, 0, 50, 1, 8'h0c, 32'h0002_0001);
        add_row(MCF_ETH_DST, MCF_ETH_TYPE, 16'h1, 16'd0, 2'd0, 1, 0, 0, 8'h00, 0);
        add_row(MCF_ETH_DST, MCF_ETH_TYPE, 16'h1, 16'd0, 2'd1, 1, 0, 0, 8'h00, 0);
        add_row(MCF_ETH_DST, MCF_ETH_TYPE, 16'h1, 16'd0, 2'd2, 1, 0, 0, 8'h00, 0);
        add_row(MCF_ETH_DST, MCF_ETH_TYPE, 16'h2, 16'd0, 2'd3, 1, 150, 0, 8'h00, 0);
        limit = 200 + 10 * rows.size();
        foreach (rows[i]) limit += rows[i].gap;
        fork
            begin
                #(limit * 100);
                $display("Timeout: the tests did not finish within %0d cycles", limit);
                $display("Done: errors found");
                $finish;
            end
        join_none
        repeat (2) @(posedge rx_clk);
        rst <= 1'b0;
        @(posedge rx_clk);
        read_all_regs("reset values");
        foreach (rows[i]) begin
            prev = err_cnt;
            if (rows[i].cfg_wr) axi_write(rows[i].cfg_addr, rows[i].cfg_data);
            q = rows[i].quanta;
            if (rows[i].rnd_q) begin
                take_bits(4, q);
                q = q + 1;
            end
            mcf_in <= '{rows[i].dst, rows[i].etype, rows[i].opcode, q[15:0], rows[i].ch};
            mcf_valid <= 1'b1;
            @(posedge rx_clk);
            mcf_valid <= 1'b0;
            repeat (rows[i].gap) @(posedge rx_clk);
            test_cnt++;
            $display("test %0d frame ch %0d quanta %0d: %0s", test_cnt, rows[i].ch, q,
                     err_cnt == prev ? "ok" : "failed");
        end
        read_all_regs("event counters");
        total = err_cnt + dut.csr_inst.props.fail_cnt;  // Assertion failures count as errors
        $display("%0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, total);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
